// ==== include/flow_cfg.svh ====
// Build-time sizes for the time-gated flow controller, included by packages and benches

`ifndef FLOW_CFG_SVH
`define FLOW_CFG_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------

// One stream beat carries 64 data bits
// Header beats reuse the data field as the timestamp
`define FLOW_DATA_W 64

// System time and header timestamps share this width
`define FLOW_TIME_W 64

// Release delta programmed through the CSR
`define FLOW_DELTA_W 32

// ----------------------------------------------------------------------
// Buffering
// ----------------------------------------------------------------------

// Default ingress buffer depth in beats
// Must stay a power of two so the pointers wrap naturally
`define FLOW_FIFO_DEPTH 1024

`endif

// ==== source/flow_stream_pkg.sv ====
// Stream-side types for the flow controller: beat layout and release FSM states

`default_nettype none

`include "flow_cfg.svh"

package flow_stream_pkg;

   // ----------------------------------------------------------------------
   // Beat format
   // ----------------------------------------------------------------------

   // One transfer on either stream port
   // First beat of a packet holds the scheduled timestamp in data
   // Later beats are opaque payload
   typedef struct packed {
      logic [`FLOW_DATA_W-1:0] data;
      // High on the final beat of a packet
      logic                    last;
   } stream_beat_t;

   // ----------------------------------------------------------------------
   // Release control states
   // ----------------------------------------------------------------------

   // WAIT_HEADER  next head beat is a header, not yet checked
   // HOLD_HEADER  header at the head is waiting for its time
   // PASS_PAYLOAD header has left, payload flows until last
   typedef enum logic [1:0] {
      WAIT_HEADER  = 2'd0,
      HOLD_HEADER  = 2'd1,
      PASS_PAYLOAD = 2'd2
   } release_state_t;

endpackage

`default_nettype wire

// ==== source/flow_csr_pkg.sv ====
// Control and timing types for the flow controller: CSR fields and system time

`default_nettype none

`include "flow_cfg.svh"

package flow_csr_pkg;

   // Free-running tick count since reset_time
   typedef logic [`FLOW_TIME_W-1:0] sys_time_t;

   // ----------------------------------------------------------------------
   // Control register
   // ----------------------------------------------------------------------

   // Static while packets are in flight
   // enable low freezes header release
   // time_delta lets headers leave this many ticks ahead of their timestamp
   typedef struct packed {
      logic                     enable;
      logic [`FLOW_DELTA_W-1:0] time_delta;
   } flow_csr_t;

endpackage

`default_nettype wire

// ==== source/system_time_counter.sv ====
// System time source; instantiate once and fan sys_time out to the gating logic

`default_nettype none

module system_time_counter
   import flow_csr_pkg::*;
(
   input  wire logic clk,
   input  wire logic reset_time,
   output sys_time_t sys_time
);

   // Counts clock ticks, zero in the first cycle after reset
   always_ff @(posedge clk) begin
      if (reset_time) begin
         sys_time <= '0;
      end else begin
         sys_time <= sys_time + sys_time_t'(1);
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------

   // Time never skips or stalls once reset has been released
   // Release decisions downstream depend on this
   property p_time_steps_by_one;
      @(posedge clk) disable iff (reset_time)
         !$past(reset_time) |-> (sys_time == $past(sys_time) + sys_time_t'(1));
   endproperty

   a_time_steps_by_one : assert property (p_time_steps_by_one)
      else $error("system time did not advance by one tick");

endmodule

`default_nettype wire

// ==== source/ingress_fifo.sv ====
// Ingress beat buffer; absorbs packets ahead of their release time and shows the head beat

`default_nettype none

`include "flow_cfg.svh"

module ingress_fifo
   import flow_stream_pkg::*;
#(
   parameter int DEPTH = `FLOW_FIFO_DEPTH
)
(
   input  wire logic   clk,
   input  wire logic   reset_time,
   // Write side
   input  wire stream_beat_t in_beat,
   input  wire logic   in_valid,
   output logic        in_ready,
   // Read side, head beat is visible without a read request
   output stream_beat_t head_beat,
   output logic        head_valid,
   input  wire logic   head_pop
);

   localparam int ADDR_W = $clog2(DEPTH);

   // Beat storage
   stream_beat_t mem [DEPTH];

   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   // One bit wider than the pointers so full is distinct from empty
   logic [ADDR_W:0]   count;

   logic wr_en;
   logic rd_en;

   // ----------------------------------------------------------------------
   // Handshake
   // ----------------------------------------------------------------------

   // Only a full buffer pushes back on the source
   assign in_ready   = (count != (ADDR_W+1)'(DEPTH));
   assign head_valid = (count != '0);

   assign wr_en = in_valid && in_ready;
   assign rd_en = head_pop;

   // Head comes straight from storage, so a beat written at edge N
   // can be popped at edge N+1
   assign head_beat = mem[rd_ptr];

   // ----------------------------------------------------------------------
   // Storage and pointers
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_beat;
      end
   end

   // Pointers wrap on their own since DEPTH is a power of two
   always_ff @(posedge clk) begin
      if (reset_time) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous write and pop leaves occupancy unchanged
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------

   // Release logic must never pop a beat that is not there
   a_no_pop_empty : assert property (@(posedge clk) disable iff (reset_time)
      head_pop |-> head_valid)
      else $error("ingress FIFO popped while empty");

   // Pointers meeting over stored data means every slot is taken
   a_no_overflow : assert property (@(posedge clk) disable iff (reset_time)
      ((count != '0) && (wr_ptr == rd_ptr)) |-> !wr_en)
      else $error("ingress FIFO written while full");

endmodule

`default_nettype wire

// ==== source/release_control.sv ====
// Release FSM; holds each packet header until its scheduled time, then lets the packet through

`default_nettype none

module release_control
   import flow_stream_pkg::*;
   import flow_csr_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset_time,
   input  wire flow_csr_t csr,
   input  wire sys_time_t sys_time,
   // Head of the ingress buffer
   input  wire stream_beat_t head_beat,
   input  wire logic   head_valid,
   output logic        head_pop,
   // Toward the egress stage
   output stream_beat_t rel_beat,
   output logic        rel_valid,
   input  wire logic   rel_ready
);

   localparam int TIME_W = $bits(sys_time_t);

   // Extra bit keeps the sum from wrapping near the top of time
   typedef logic [TIME_W:0] wide_time_t;

   release_state_t state_q;
   release_state_t state_d;

   wide_time_t release_time;
   wide_time_t header_time;
   logic       header_due;
   logic       may_leave;

   // ----------------------------------------------------------------------
   // Release rule
   // ----------------------------------------------------------------------

   // Current time pushed forward by the programmed delta
   assign release_time = wide_time_t'(sys_time) + wide_time_t'(csr.time_delta);

   // Header data field is the scheduled timestamp
   assign header_time = wide_time_t'(sys_time_t'(head_beat.data));

   // Header may go once enabled and its time has come
   assign header_due = csr.enable && (release_time >= header_time);

   // Payload beats are never gated, only the header is
   assign may_leave = (state_q == PASS_PAYLOAD) || header_due;

   assign rel_valid = head_valid && may_leave;
   assign rel_beat  = head_beat;

   // Pop only on an actual transfer into the egress stage
   assign head_pop = rel_valid && rel_ready;

   // ----------------------------------------------------------------------
   // State machine
   // ----------------------------------------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_HEADER, HOLD_HEADER: begin
            if (head_pop) begin
               // Single-beat packet goes straight back to header search
               state_d = head_beat.last ? WAIT_HEADER : PASS_PAYLOAD;
            end else if (head_valid && !header_due) begin
               state_d = HOLD_HEADER;
            end
         end
         PASS_PAYLOAD: begin
            // Next beat after the last one is a new header
            if (head_pop && head_beat.last) begin
               state_d = WAIT_HEADER;
            end
         end
         default: begin
            state_d = WAIT_HEADER;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_time) begin
         state_q <= WAIT_HEADER;
      end else begin
         state_q <= state_d;
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------

   // A header never leaves early or while release is frozen
   // Raw timestamp compared against time plus delta at the pop
   property p_no_early_header;
      @(posedge clk) disable iff (reset_time)
         (head_pop && (state_q != PASS_PAYLOAD)) |->
            (csr.enable && (({1'b0, sys_time} + csr.time_delta) >= {1'b0, head_beat.data}));
   endproperty

   a_no_early_header : assert property (p_no_early_header)
      else $error("header popped before its release time");

endmodule

`default_nettype wire

// ==== source/egress_stage.sv ====
// Output skid register; decouples downstream back-pressure from the buffer read path

`default_nettype none

module egress_stage
   import flow_stream_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset_time,
   // From the release logic
   input  wire stream_beat_t rel_beat,
   input  wire logic   rel_valid,
   output logic        rel_ready,
   // Downstream port
   output stream_beat_t out_beat,
   output logic        out_valid,
   input  wire logic   out_ready
);

   // Main entry drives the output, skid entry catches a beat during a stall
   stream_beat_t main_q;
   stream_beat_t skid_q;
   logic         main_valid;
   logic         skid_valid;

   logic accept;
   logic drain;

   // Ready depends only on local state, no path from out_ready
   assign rel_ready = !skid_valid;

   assign accept = rel_valid && rel_ready;
   assign drain  = main_valid && out_ready;

   assign out_beat  = main_q;
   assign out_valid = main_valid;

   // ----------------------------------------------------------------------
   // Entry occupancy
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset_time) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         // Main stays full if it kept its beat, took a new one or took the skid beat
         main_valid <= (main_valid && !out_ready) || accept || skid_valid;
         // Skid fills only when a beat arrives behind a stalled main entry
         skid_valid <= skid_valid ? !drain : (accept && main_valid && !out_ready);
      end
   end

   // ----------------------------------------------------------------------
   // Payload
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (skid_valid) begin
         // Skid beat is older, it moves up once main drains
         if (drain) begin
            main_q <= skid_q;
         end
      end else if (accept) begin
         if (!main_valid || out_ready) begin
            main_q <= rel_beat;
         end else begin
            skid_q <= rel_beat;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Checks
   // ----------------------------------------------------------------------

   // Stalled output must hold its beat until taken
   a_stall_stable : assert property (@(posedge clk) disable iff (reset_time)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
      else $error("output beat changed while stalled");

endmodule

`default_nettype wire

// ==== source/flow_control_time.sv ====
// Top of the time-gated packet flow controller; instantiate in the radio datapath

`default_nettype none

module flow_control_time
   import flow_stream_pkg::*;
   import flow_csr_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset_time,
   input  wire flow_csr_t csr,
   // Upstream packets
   input  wire stream_beat_t in_beat,
   input  wire logic   in_valid,
   output logic        in_ready,
   // Downstream packets
   output stream_beat_t out_beat,
   output logic        out_valid,
   input  wire logic   out_ready,
   // Current tick count
   output sys_time_t   system_time
);

   // Buffer head toward the release logic
   stream_beat_t head_beat;
   logic         head_valid;
   logic         head_pop;

   // Released beats toward the output register
   stream_beat_t rel_beat;
   logic         rel_valid;
   logic         rel_ready;

   // ----------------------------------------------------------------------
   // Datapath
   // ----------------------------------------------------------------------

   system_time_counter u_time (
      .clk        (clk),
      .reset_time (reset_time),
      .sys_time   (system_time)
   );

   ingress_fifo u_fifo (
      .clk        (clk),
      .reset_time (reset_time),
      .in_beat    (in_beat),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .head_beat  (head_beat),
      .head_valid (head_valid),
      .head_pop   (head_pop)
   );

   release_control u_release (
      .clk        (clk),
      .reset_time (reset_time),
      .csr        (csr),
      .sys_time   (system_time),
      .head_beat  (head_beat),
      .head_valid (head_valid),
      .head_pop   (head_pop),
      .rel_beat   (rel_beat),
      .rel_valid  (rel_valid),
      .rel_ready  (rel_ready)
   );

   egress_stage u_egress (
      .clk        (clk),
      .reset_time (reset_time),
      .rel_beat   (rel_beat),
      .rel_valid  (rel_valid),
      .rel_ready  (rel_ready),
      .out_beat   (out_beat),
      .out_valid  (out_valid),
      .out_ready  (out_ready)
   );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source; instantiate once in the testbench top

`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 4
)
(
   output logic clk,
   output logic reset_time
);

   timeunit 1ns;
   timeprecision 1ps;

   // Free-running clock, low at time zero
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset held over the first edges, dropped with the usual drive delay
   initial begin
      reset_time = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #10;
      reset_time = 1'b0;
   end

endmodule

`default_nettype wire

// ==== dv/tb_flow_control_time.sv ====
// Testbench top for the flow controller; drives packets, predicts release times, scores output

`default_nettype none

`include "flow_cfg.svh"

module tb_flow_control_time
   import flow_stream_pkg::*;
   import flow_csr_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // ----------------------------------------------------------------------
   // Test sizes and run limit
   // ----------------------------------------------------------------------

   localparam logic [`FLOW_DELTA_W-1:0] DELTA = 5;
   localparam int EXACT_PKTS  = 10;
   localparam int EXACT_GAP   = 10;
   localparam int EXACT_LEAD  = 200;
   localparam int LATE_PKTS   = 8;
   localparam int HOLD_PKTS   = 5;
   localparam int HOLD_CYCLES = 30;
   localparam int STALL_PKTS  = 20;
   localparam int MAX_BEATS   = 8;
   localparam int SCHED_SPAN  = EXACT_LEAD + EXACT_PKTS * EXACT_GAP + HOLD_CYCLES
                                + (LATE_PKTS + HOLD_PKTS + STALL_PKTS) * MAX_BEATS;
   localparam int CYCLE_LIMIT = 2 * SCHED_SPAN + 2000;

   logic         clk;
   logic         reset_time;
   flow_csr_t    csr;
   stream_beat_t in_beat;
   logic         in_valid;
   logic         in_ready;
   stream_beat_t out_beat;
   logic         out_valid;
   logic         out_ready;
   sys_time_t    system_time;

   // Phase flags set by the stimulus
   logic exact_mode;
   logic stall_mode;
   logic expect_quiet;

   logic [31:0] data_rng;
   logic [31:0] stall_rng;
   logic        ready_next;

   // Expected beats in input order, with the write time of each
   logic [`FLOW_DATA_W-1:0] q_data [$];
   logic                    q_last [$];
   logic                    q_hdr [$];
   logic                    q_exact [$];
   sys_time_t               q_wtime [$];

   // Output tracking
   logic         in_is_header;
   logic         held_prev;
   stream_beat_t held_beat;
   sys_time_t    appear_time;
   sys_time_t    prev_appear;
   sys_time_t    prev_last_appear;
   sys_time_t    time_ref;

   int errors;
   int beats_in;
   int beats_out;
   int cycles;

   tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clk (
      .clk        (clk),
      .reset_time (reset_time)
   );

   flow_control_time dut0 (
      .clk         (clk),
      .reset_time  (reset_time),
      .csr         (csr),
      .in_beat     (in_beat),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .out_beat    (out_beat),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .system_time (system_time)
   );

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Random value in 0 .. n-1 from the data generator
   function automatic int draw(input int n);
      data_rng = lcg_next(data_rng);
      return int'(data_rng[23:8]) % n;
   endfunction

   // Header may pop once time plus delta reaches the timestamp,
   // but not before it sits at the FIFO head; it shows one tick later
   function automatic sys_time_t expected_appear(input sys_time_t ts,
                                                 input logic [`FLOW_DELTA_W-1:0] delta,
                                                 input sys_time_t head_at);
      sys_time_t earliest;
      earliest = (ts > sys_time_t'(delta)) ? ts - sys_time_t'(delta) : '0;
      return ((earliest > head_at) ? earliest : head_at) + sys_time_t'(1);
   endfunction

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   // Hold one beat on the input until it transfers
   task automatic send_beat(input logic [`FLOW_DATA_W-1:0] data, input logic last);
      in_beat.data = data;
      in_beat.last = last;
      in_valid     = 1'b1;
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      next_cycle();
      in_valid = 1'b0;
   endtask

   task automatic send_packet(input sys_time_t ts, input int nbeats);
      logic [31:0] lo;
      send_beat(ts, nbeats == 1);
      for (int i = 1; i < nbeats; i++) begin
         lo       = lcg_next(data_rng);
         data_rng = lcg_next(lo);
         send_beat({data_rng, lo}, i == nbeats - 1);
      end
   endtask

   task automatic wait_drain();
      @(negedge clk);
      while (q_data.size() != 0) @(negedge clk);
      next_cycle();
   endtask

   task automatic report_counts();
      $display("Run summary: %0d errors, %0d beats in, %0d beats out, %0d still expected",
               errors, beats_in, beats_out, q_data.size());
   endtask

   // One output transfer against the oldest expected beat
   task automatic score_output();
      logic      hdr;
      logic      exact;
      sys_time_t wtime;
      sys_time_t head_at;
      if (q_data.size() == 0) begin
         errors++;
         $display("ERROR at %0t ns: output beat %h arrived with nothing expected",
                  $time, out_beat.data);
         return;
      end
      hdr   = q_hdr.pop_front();
      exact = q_exact.pop_front();
      wtime = q_wtime.pop_front();
      check("beat data", out_beat.data, q_data.pop_front());
      check("beat last flag", 64'(out_beat.last), 64'(q_last.pop_front()));
      if (hdr) begin
         check("header released before its time",
               64'(({1'b0, appear_time} + csr.time_delta) >= {1'b0, out_beat.data}), 64'd1);
         if (exact) begin
            head_at = (wtime + 1 > prev_last_appear) ? wtime + 1 : prev_last_appear;
            check("header release time", appear_time,
                  expected_appear(out_beat.data, csr.time_delta, head_at));
         end
      end else if (exact) begin
         check("payload gap", appear_time, prev_appear + 1);
      end
      if (out_beat.last) begin
         prev_last_appear = appear_time;
      end
      prev_appear = appear_time;
      beats_out++;
   endtask

   // ----------------------------------------------------------------------
   // Monitor and compare
   // ----------------------------------------------------------------------

   always @(posedge clk) begin
      if (reset_time) begin
         in_is_header     = 1'b1;
         held_prev        = 1'b0;
         prev_appear      = '0;
         prev_last_appear = '0;
         time_ref         = '0;
      end else begin
         // Tick count starts at zero after reset and steps by one
         check("system time", system_time, time_ref);
         time_ref = time_ref + sys_time_t'(1);
         // Beats in flight never fill the buffer in this run
         if (q_data.size() < `FLOW_FIFO_DEPTH) begin
            check("in_ready low with room in the buffer", 64'(in_ready), 64'd1);
         end
         // Record input transfers first, a beat cannot leave in the same cycle
         if (in_valid && in_ready) begin
            q_data.push_back(in_beat.data);
            q_last.push_back(in_beat.last);
            q_hdr.push_back(in_is_header);
            q_exact.push_back(exact_mode);
            q_wtime.push_back(system_time);
            in_is_header = in_beat.last;
            beats_in++;
         end
         if (expect_quiet) begin
            check("output while release frozen", 64'(out_valid), 64'd0);
         end
         if (held_prev) begin
            check("out_valid dropped while stalled", 64'(out_valid), 64'd1);
            check("out_beat data changed while stalled", out_beat.data, held_beat.data);
            check("out_beat last changed while stalled", 64'(out_beat.last),
                  64'(held_beat.last));
         end
         // New beat on the output, note when it first shows
         if (out_valid && !held_prev) begin
            appear_time = system_time;
         end
         if (out_valid && out_ready) begin
            score_output();
         end
         held_prev = out_valid && !out_ready;
         held_beat = out_beat;
      end
   end

   // Downstream ready, random only in the back-pressure phase
   always @(posedge clk) begin
      if (stall_mode) begin
         stall_rng  = lcg_next(stall_rng);
         ready_next = (stall_rng[17:16] != 2'b00);
      end else begin
         ready_next = 1'b1;
      end
      #10;
      out_ready = ready_next;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("ERROR: run timed out after %0d cycles", cycles);
         report_counts();
         $display("sim failed");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------

   initial begin
      sys_time_t base;
      csr.enable     = 1'b1;
      csr.time_delta = DELTA;
      in_beat        = '0;
      in_valid       = 1'b0;
      out_ready      = 1'b1;
      exact_mode     = 1'b0;
      stall_mode     = 1'b0;
      expect_quiet   = 1'b0;
      data_rng       = 32'h3457;
      stall_rng      = 32'h3457;
      errors         = 0;
      beats_in       = 0;
      beats_out      = 0;
      cycles         = 0;

      do @(posedge clk); while (reset_time !== 1'b0);
      #10;

      // Packets loaded well ahead, ten cycles apart
      exact_mode = 1'b1;
      base = system_time;
      for (int p = 0; p < EXACT_PKTS; p++) begin
         send_packet(base + EXACT_LEAD + p * EXACT_GAP, draw(4) + 1);
      end
      wait_drain();

      // Timestamps already in the past
      for (int p = 0; p < LATE_PKTS; p++) begin
         send_packet(sys_time_t'(draw(100)), draw(6) + 1);
      end
      wait_drain();
      exact_mode = 1'b0;

      // Release frozen, then drained in order
      csr.enable   = 1'b0;
      expect_quiet = 1'b1;
      for (int p = 0; p < HOLD_PKTS; p++) begin
         send_packet(sys_time_t'(draw(100)), draw(MAX_BEATS) + 1);
      end
      repeat (HOLD_CYCLES) next_cycle();
      csr.enable   = 1'b1;
      expect_quiet = 1'b0;
      wait_drain();

      // Random downstream stalls, mix of due and future headers
      stall_mode = 1'b1;
      for (int p = 0; p < STALL_PKTS; p++) begin
         send_packet(system_time + sys_time_t'(draw(40)), draw(MAX_BEATS) + 1);
      end
      wait_drain();
      stall_mode = 1'b0;

      repeat (5) next_cycle();
      report_counts();
      if (errors == 0 && q_data.size() == 0 && beats_in == beats_out) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/flow_stream_pkg.sv
source/flow_csr_pkg.sv
source/system_time_counter.sv
source/ingress_fifo.sv
source/release_control.sv
source/egress_stage.sv
source/flow_control_time.sv
dv/tb_clock_gen.sv
dv/tb_flow_control_time.sv
